/* src/rv_isa_pkg.sv */
package rv_isa_pkg;

  // Architectural register index
  // x0 is hardwired to zero, so it never carries a dependency
  typedef logic [4:0] reg_idx_t;

  localparam reg_idx_t REG_X0 = 5'd0;

  // Decoded instruction class as seen by the pipeline control
  typedef enum logic [2:0] {
    OP_ALU    = 3'd0,
    OP_LOAD   = 3'd1,
    OP_STORE  = 3'd2,
    OP_CSR    = 3'd3,
    OP_MUL    = 3'd4,
    OP_BRANCH = 3'd5
  } op_class_e;

  // Where the value written to rd comes from
  // RES_PC4 is the link address of JAL and JALR
  typedef enum logic [2:0] {
    RES_ALU = 3'd0,
    RES_MEM = 3'd1,
    RES_CSR = 3'd2,
    RES_M   = 3'd3,
    RES_PC4 = 3'd4
  } res_src_e;

endpackage

/* src/rv_pipe_pkg.sv */
package rv_pipe_pkg;

  // Next PC source presented by the fetch side
  typedef enum logic [1:0] {
    PC_SEL_SEQ       = 2'd0,
    PC_SEL_PREDICTED = 2'd1,
    PC_SEL_REDIRECT  = 2'd2
  } pc_sel_e;

  // Bypass source for one ID-stage operand
  typedef enum logic [1:0] {
    FWD_NONE = 2'd0,
    FWD_MEM  = 2'd1,
    FWD_WB   = 2'd2
  } fwd_sel_e;

  // Data memory flavour
  // BRAM load data only shows up once the load has moved on to WB
  typedef enum logic {
    MEM_TYPE_SRAM = 1'b0,
    MEM_TYPE_BRAM = 1'b1
  } mem_type_e;

  localparam int        DEF_FWD         = 1;
  localparam int        DEF_FWD_REGFILE = 1;
  localparam mem_type_e DEF_MEM_TYPE    = MEM_TYPE_BRAM;

  // Number of cycles a multiply or divide occupies EX
  localparam int M_CYCLES = 4;
  // Wide enough to hold M_CYCLES itself
  localparam int M_CNT_W  = $clog2(M_CYCLES + 1);

endpackage

/* src/rv_dest_if.sv */
`timescale 1ns/1ps

interface rv_dest_if
  import rv_isa_pkg::*;
();

  // Destination metadata of the instruction held in one stage
  reg_idx_t  rd;
  // Register write enable, already qualified by valid
  logic      reg_write;
  logic      valid;
  op_class_e op_class;
  res_src_e  res_src;

  // Driven by the stage registers
  modport stage (
    output rd,
    output reg_write,
    output valid,
    output op_class,
    output res_src
  );

  // Read by hazard detection and the bypass selector
  modport watch (
    input rd,
    input reg_write,
    input valid,
    input op_class,
    input res_src
  );

endinterface

/* src/rv_id_stage.sv */
`timescale 1ns/1ps

module rv_id_stage
  import rv_isa_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      in_valid,
  output logic      in_ready,
  input  reg_idx_t  in_rs1,
  input  reg_idx_t  in_rs2,
  input  reg_idx_t  in_rd,
  input  logic      in_rs1_used,
  input  logic      in_rs2_used,
  input  logic      in_reg_write,
  input  op_class_e in_op,
  input  logic      stall,
  input  logic      flush,
  output logic      issue,
  output reg_idx_t  id_rs1,
  output reg_idx_t  id_rs2,
  output logic      id_rs1_used,
  output logic      id_rs2_used,
  output reg_idx_t  id_rd,
  output logic      id_reg_write,
  output op_class_e id_op,
  output logic      id_valid
);

  // One-entry decode slot
  // It can take a new instruction in the same cycle the current one issues
  logic      slot_valid;
  // Keeps in_ready low until the first cycle after reset
  logic      out_of_reset;
  logic      accept;
  reg_idx_t  rs1_q;
  reg_idx_t  rs2_q;
  reg_idx_t  rd_q;
  logic      rs1_used_q;
  logic      rs2_used_q;
  logic      reg_write_q;
  op_class_e op_q;

  // A stall holds the slot and EX gets a bubble
  // A flush drops both the slot and any instruction accepted this cycle
  assign issue    = slot_valid && !stall && !flush;
  assign in_ready = out_of_reset && (!slot_valid || issue);
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_of_reset <= 1'b0;
      slot_valid   <= 1'b0;
    end else begin
      out_of_reset <= 1'b1;
      if (flush) begin
        slot_valid <= 1'b0;
      end else if (accept) begin
        slot_valid <= 1'b1;
      end else if (issue) begin
        slot_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rs1_q       <= in_rs1;
      rs2_q       <= in_rs2;
      rd_q        <= in_rd;
      rs1_used_q  <= in_rs1_used;
      rs2_used_q  <= in_rs2_used;
      reg_write_q <= in_reg_write;
      op_q        <= in_op;
    end
  end

  assign id_valid     = slot_valid;
  assign id_rs1       = rs1_q;
  assign id_rs2       = rs2_q;
  assign id_rd        = rd_q;
  assign id_reg_write = reg_write_q;
  assign id_op        = op_q;
  // Source use only counts while a real instruction sits in the slot
  assign id_rs1_used  = slot_valid && rs1_used_q;
  assign id_rs2_used  = slot_valid && rs2_used_q;

  // A stalled instruction must be the same one on the next cycle
  a_slot_held: assert property (@(posedge clk) disable iff (rst)
    (slot_valid && !issue && !flush) |=> (slot_valid && $stable({rs1_q, rs2_q, rd_q, op_q})));

endmodule

/* src/rv_stage_track.sv */
`timescale 1ns/1ps

module rv_stage_track
  import rv_isa_pkg::*, rv_pipe_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            issue,
  input  reg_idx_t        id_rd,
  input  logic            id_reg_write,
  input  op_class_e       id_op,
  input  logic            ex_mem_flush,
  input  logic            mispredicted_mem,
  output logic            op_active_ex,
  rv_dest_if.stage        ex,
  rv_dest_if.stage        mem,
  rv_dest_if.stage        wb,
  output logic            ret_valid,
  output reg_idx_t        ret_rd
);

  // Result source follows from the instruction class
  // Stores and ALU ops share RES_ALU
  function automatic res_src_e res_of(op_class_e op);
    case (op)
      OP_LOAD:   return RES_MEM;
      OP_CSR:    return RES_CSR;
      OP_MUL:    return RES_M;
      OP_BRANCH: return RES_PC4;
      default:   return RES_ALU;
    endcase
  endfunction

  logic               ex_valid;
  logic               mem_valid;
  logic               wb_valid;
  reg_idx_t           ex_rd;
  reg_idx_t           mem_rd;
  reg_idx_t           wb_rd;
  logic               ex_wr;
  logic               mem_wr;
  logic               wb_wr;
  op_class_e          ex_op;
  op_class_e          mem_op;
  op_class_e          wb_op;
  logic [M_CNT_W-1:0] m_cnt;
  logic               ex_hold;

  // An M op counts its cycles in EX and releases EX on the last one
  assign op_active_ex = ex_valid && (ex_op == OP_MUL) && (m_cnt < M_CNT_W'(M_CYCLES - 1));
  // A misprediction in MEM kills a busy M op too
  assign ex_hold = op_active_ex && !mispredicted_mem;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid  <= 1'b0;
      mem_valid <= 1'b0;
      wb_valid  <= 1'b0;
      m_cnt     <= '0;
    end else begin
      if (!ex_hold) begin
        ex_valid <= issue;
      end
      // ex_mem_flush turns the EX instruction into a bubble for MEM
      mem_valid <= ex_valid && !ex_mem_flush;
      wb_valid  <= mem_valid;
      m_cnt     <= ex_hold ? m_cnt + 1'b1 : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue && !ex_hold) begin
      ex_rd <= id_rd;
      ex_wr <= id_reg_write;
      ex_op <= id_op;
    end
    mem_rd <= ex_rd;
    mem_wr <= ex_wr;
    mem_op <= ex_op;
    wb_rd  <= mem_rd;
    wb_wr  <= mem_wr;
    wb_op  <= mem_op;
  end

  assign ex.valid     = ex_valid;
  assign ex.rd        = ex_rd;
  assign ex.reg_write = ex_valid && ex_wr;
  assign ex.op_class  = ex_op;
  assign ex.res_src   = res_of(ex_op);

  assign mem.valid     = mem_valid;
  assign mem.rd        = mem_rd;
  assign mem.reg_write = mem_valid && mem_wr;
  assign mem.op_class  = mem_op;
  assign mem.res_src   = res_of(mem_op);

  assign wb.valid     = wb_valid;
  assign wb.rd        = wb_rd;
  assign wb.reg_write = wb_valid && wb_wr;
  assign wb.op_class  = wb_op;
  assign wb.res_src   = res_of(wb_op);

  // Every instruction leaving WB retires
  assign ret_valid = wb_valid;
  assign ret_rd    = wb_rd;

  a_m_cnt_range: assert property (@(posedge clk) disable iff (rst)
    m_cnt < M_CNT_W'(M_CYCLES));

endmodule

/* src/rv_hazard.sv */
`timescale 1ns/1ps

module rv_hazard
  import rv_isa_pkg::*, rv_pipe_pkg::*;
#(
  parameter int        FWD         = DEF_FWD,
  parameter int        FWD_REGFILE = DEF_FWD_REGFILE,
  parameter mem_type_e MEM_TYPE    = DEF_MEM_TYPE
) (
  input  reg_idx_t   id_rs1,
  input  reg_idx_t   id_rs2,
  input  logic       id_rs1_used,
  input  logic       id_rs2_used,
  rv_dest_if.watch   ex,
  rv_dest_if.watch   mem,
  rv_dest_if.watch   wb,
  input  logic       op_active_ex,
  input  pc_sel_e    pc_sel,
  input  logic       mispredicted_mem,
  input  logic       btb_pred_taken,
  input  logic       ras_pred_taken,
  output logic       data_hazard,
  output logic       if_id_flush,
  output logic       id_ex_flush,
  output logic       ex_mem_flush
);

  // True when a producer writing rd feeds a used source register
  function automatic logic raw(reg_idx_t rd, logic wr, reg_idx_t rs, logic used);
    return wr && (rd != REG_X0) && used && (rd == rs);
  endfunction

  logic ex_match;
  logic mem_match;
  logic wb_match;
  logic pc_redirect;
  logic control_flush;
  logic pred_flush;

  assign ex_match  = raw(ex.rd, ex.reg_write, id_rs1, id_rs1_used) ||
                     raw(ex.rd, ex.reg_write, id_rs2, id_rs2_used);
  assign mem_match = raw(mem.rd, mem.reg_write, id_rs1, id_rs1_used) ||
                     raw(mem.rd, mem.reg_write, id_rs2, id_rs2_used);

  // With a write-through register file, WB results are seen by ID reads directly
  if (FWD_REGFILE != 0) begin : g_wb_regfile_fwd
    assign wb_match = 1'b0;
  end else begin : g_wb_stall
    assign wb_match = raw(wb.rd, wb.reg_write, id_rs1, id_rs1_used) ||
                      raw(wb.rd, wb.reg_write, id_rs2, id_rs2_used);
  end

  // Redirect from EX or a misprediction resolved in MEM
  // Either one kills whatever sits behind it
  assign pc_redirect   = (pc_sel == PC_SEL_REDIRECT);
  assign control_flush = pc_redirect || mispredicted_mem;

  if (FWD != 0) begin : g_fwd
    // Results that are not ready while their producer sits in EX
    logic late_ex;
    // Results that the MEM bypass cannot supply
    logic late_mem;

    assign late_ex = (ex.op_class == OP_LOAD) || (ex.op_class == OP_CSR) ||
                     (ex.op_class == OP_MUL);

    if (MEM_TYPE == MEM_TYPE_BRAM) begin : g_bram
      // BRAM load data only arrives in WB
      assign late_mem = (mem.op_class == OP_LOAD) || (mem.res_src == RES_CSR) ||
                        (mem.res_src == RES_M);
    end else begin : g_sram
      assign late_mem = (mem.res_src == RES_CSR) || (mem.res_src == RES_M);
    end

    // Everything else is covered by the ID-stage bypass
    assign data_hazard = ((late_ex && ex_match) || (late_mem && mem_match) || wb_match) &&
                         !control_flush;
  end else begin : g_no_fwd
    // Without bypassing every RAW dependency waits for the register file
    assign data_hazard = (ex_match || mem_match || wb_match) && !control_flush;
  end

  // Predictions made at ID (static or RAS) have already fetched the wrong
  // sequential instruction, while BTB hits redirect fetch in time
  // The flush only applies while the pipeline moves
  assign pred_flush = (pc_sel == PC_SEL_PREDICTED) && (!btb_pred_taken || ras_pred_taken) &&
                      !data_hazard && !op_active_ex;

  assign if_id_flush  = control_flush || pred_flush;
  assign id_ex_flush  = control_flush;
  // A busy M op sends bubbles to MEM until its last EX cycle
  assign ex_mem_flush = mispredicted_mem || op_active_ex;

  // A flushed consumer must never also hold the pipeline
  a_no_stall_on_flush: assert final (!(data_hazard && id_ex_flush));

endmodule

/* src/rv_fwd_id.sv */
`timescale 1ns/1ps

module rv_fwd_id
  import rv_isa_pkg::*, rv_pipe_pkg::*;
(
  input  reg_idx_t  id_rs1,
  input  reg_idx_t  id_rs2,
  rv_dest_if.watch  mem,
  rv_dest_if.watch  wb,
  output fwd_sel_e  rs1_sel,
  output fwd_sel_e  rs2_sel
);

  // Bypass choice for one source register
  // MEM wins over WB because it holds the younger value
  function automatic fwd_sel_e pick(
    reg_idx_t rs,
    reg_idx_t mem_rd,
    logic     mem_wr,
    res_src_e mem_src,
    reg_idx_t wb_rd,
    logic     wb_wr
  );
    logic mem_ready;
    // Only ALU results and link addresses exist by the time an op reaches MEM
    mem_ready = (mem_src == RES_ALU) || (mem_src == RES_PC4);
    if (rs == REG_X0) begin
      return FWD_NONE;
    end else if (mem_wr && mem_ready && (mem_rd == rs)) begin
      return FWD_MEM;
    end else if (wb_wr && (wb_rd == rs)) begin
      return FWD_WB;
    end
    return FWD_NONE;
  endfunction

  // Loads, CSR reads and M results in MEM are left to the hazard unit,
  // which stalls until they reach WB
  assign rs1_sel = pick(id_rs1, mem.rd, mem.reg_write, mem.res_src, wb.rd, wb.reg_write);
  assign rs2_sel = pick(id_rs2, mem.rd, mem.reg_write, mem.res_src, wb.rd, wb.reg_write);

endmodule

/* src/rv_pipe_ctrl.sv */
`timescale 1ns/1ps

module rv_pipe_ctrl
  import rv_isa_pkg::*, rv_pipe_pkg::*;
#(
  parameter int        FWD         = DEF_FWD,
  parameter int        FWD_REGFILE = DEF_FWD_REGFILE,
  parameter mem_type_e MEM_TYPE    = DEF_MEM_TYPE
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      in_valid,
  output logic      in_ready,
  input  reg_idx_t  in_rs1,
  input  reg_idx_t  in_rs2,
  input  reg_idx_t  in_rd,
  input  logic      in_rs1_used,
  input  logic      in_rs2_used,
  input  logic      in_reg_write,
  input  op_class_e in_op,
  input  pc_sel_e   pc_sel,
  input  logic      mispredicted_mem,
  input  logic      btb_pred_taken,
  input  logic      ras_pred_taken,
  output logic      data_hazard,
  output logic      if_id_flush,
  output logic      id_ex_flush,
  output logic      ex_mem_flush,
  output fwd_sel_e  fwd_rs1_sel,
  output fwd_sel_e  fwd_rs2_sel,
  output logic      ret_valid,
  output reg_idx_t  ret_rd
);

  logic      issue;
  logic      stall;
  logic      op_active_ex;
  reg_idx_t  id_rs1;
  reg_idx_t  id_rs2;
  reg_idx_t  id_rd;
  logic      id_rs1_used;
  logic      id_rs2_used;
  logic      id_reg_write;
  op_class_e id_op;

  // Destination metadata of the three stages behind ID
  rv_dest_if dest_ex ();
  rv_dest_if dest_mem ();
  rv_dest_if dest_wb ();

  // ID holds for a data hazard or a busy M op
  assign stall = data_hazard || op_active_ex;

  rv_id_stage u_id_stage (
    .clk, .rst, .in_valid, .in_ready, .in_rs1, .in_rs2, .in_rd, .in_rs1_used,
    .in_rs2_used, .in_reg_write, .in_op, .stall, .flush(if_id_flush), .issue,
    .id_rs1, .id_rs2, .id_rs1_used, .id_rs2_used, .id_rd, .id_reg_write, .id_op,
    .id_valid()
  );

  rv_stage_track u_stage_track (
    .clk, .rst, .issue, .id_rd, .id_reg_write, .id_op, .ex_mem_flush,
    .mispredicted_mem, .op_active_ex, .ex(dest_ex), .mem(dest_mem), .wb(dest_wb),
    .ret_valid, .ret_rd
  );

  rv_hazard #(
    .FWD(FWD),
    .FWD_REGFILE(FWD_REGFILE),
    .MEM_TYPE(MEM_TYPE)
  ) u_hazard (
    .id_rs1, .id_rs2, .id_rs1_used, .id_rs2_used, .ex(dest_ex), .mem(dest_mem),
    .wb(dest_wb), .op_active_ex, .pc_sel, .mispredicted_mem, .btb_pred_taken,
    .ras_pred_taken, .data_hazard, .if_id_flush, .id_ex_flush, .ex_mem_flush
  );

  rv_fwd_id u_fwd_id (
    .id_rs1, .id_rs2, .mem(dest_mem), .wb(dest_wb),
    .rs1_sel(fwd_rs1_sel), .rs2_sel(fwd_rs2_sel)
  );

endmodule

/* sim/tb_rv_pipe_ctrl.sv */
`timescale 1ns/1ps

module tb_rv_pipe_ctrl
  import rv_isa_pkg::*, rv_pipe_pkg::*;
();

  // Control event that a row raises once it reaches the stage that resolves it
  typedef enum logic [2:0] {
    EV_NONE,
    EV_REDIRECT,
    EV_MISPRED,
    EV_PRED_BTB,
    EV_PRED_NOBTB
  } event_e;

  typedef struct packed {
    op_class_e op;
    reg_idx_t  rd;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    logic      rs1_used;
    logic      rs2_used;
    event_e    ev;
  } row_t;

  localparam int NUM_ROWS    = 25;
  localparam int CYCLE_LIMIT = NUM_ROWS * (M_CYCLES + 8) + 100;

  logic      clk;
  logic      rst;
  logic      in_valid;
  logic      in_ready;
  reg_idx_t  in_rs1;
  reg_idx_t  in_rs2;
  reg_idx_t  in_rd;
  logic      in_rs1_used;
  logic      in_rs2_used;
  logic      in_reg_write;
  op_class_e in_op;
  pc_sel_e   pc_sel;
  logic      mispredicted_mem;
  logic      btb_pred_taken;
  logic      ras_pred_taken;
  logic      data_hazard;
  logic      if_id_flush;
  logic      id_ex_flush;
  logic      ex_mem_flush;
  fwd_sel_e  fwd_rs1_sel;
  fwd_sel_e  fwd_rs2_sel;
  logic      ret_valid;
  reg_idx_t  ret_rd;

  row_t rows [NUM_ROWS];
  int   num_loaded;
  // Reference pipeline, each stage holds a row index or -1 when empty
  int   id_row;
  int   ex_row;
  int   mem_row;
  int   wb_row;
  int   m_cnt;
  // Row currently offered on the input, -1 while idle
  int   cur_row;
  logic taken;
  int   cycles;
  int   checks;
  int   errors;
  int   got_ret;
  // Values predicted by the model for the current cycle
  logic m_hazard;
  logic m_busy;
  logic m_if_id;
  logic m_id_ex;
  logic m_ex_mem;
  logic m_issue;
  logic m_ready;

  rv_pipe_ctrl u_rv_pipe_ctrl (
    .clk, .rst, .in_valid, .in_ready, .in_rs1, .in_rs2, .in_rd, .in_rs1_used,
    .in_rs2_used, .in_reg_write, .in_op, .pc_sel, .mispredicted_mem, .btb_pred_taken,
    .ras_pred_taken, .data_hazard, .if_id_flush, .id_ex_flush, .ex_mem_flush,
    .fwd_rs1_sel, .fwd_rs2_sel, .ret_valid, .ret_rd
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    if (!rst) begin
      cycles <= cycles + 1;
    end
  end

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h expected %h at cycle %0d", name, got, exp, cycles);
    end
  endtask

  task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h expected %h at cycle %0d", name, got, exp, cycles);
    end
  endtask

  task automatic check_fwd(input string name, input fwd_sel_e got, input fwd_sel_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h expected %h at cycle %0d", name, got, exp, cycles);
    end
  endtask

  task automatic add_row(input op_class_e op, input int rd, input int rs1, input int rs2,
                         input logic u1, input logic u2, input event_e ev);
    rows[num_loaded] = '{op, reg_idx_t'(rd), reg_idx_t'(rs1), reg_idx_t'(rs2), u1, u2, ev};
    num_loaded++;
  endtask

  // Columns are op, rd, rs1, rs2, rs1 used, rs2 used, control event
  task automatic load_table();
    add_row(OP_ALU,     1,  0,  0, 1, 1, EV_NONE);
    add_row(OP_ALU,     2,  5,  6, 1, 1, EV_NONE);
    add_row(OP_ALU,     3,  7,  0, 1, 0, EV_NONE);
    add_row(OP_ALU,     4,  3,  2, 1, 1, EV_NONE);
    add_row(OP_ALU,     5,  4,  1, 1, 1, EV_NONE);
    add_row(OP_LOAD,    8,  1,  0, 1, 0, EV_NONE);
    add_row(OP_ALU,     9,  8,  5, 1, 1, EV_NONE);
    add_row(OP_CSR,    10,  0,  0, 0, 0, EV_NONE);
    add_row(OP_ALU,    11,  9, 10, 1, 1, EV_NONE);
    add_row(OP_MUL,    12,  4,  9, 1, 1, EV_NONE);
    add_row(OP_ALU,    13, 12,  0, 1, 0, EV_NONE);
    add_row(OP_ALU,     0, 13, 11, 1, 1, EV_NONE);
    add_row(OP_ALU,    14,  0,  0, 1, 1, EV_NONE);
    add_row(OP_BRANCH,  0, 14, 13, 1, 1, EV_REDIRECT);
    add_row(OP_ALU,    15, 14,  0, 1, 0, EV_NONE);
    add_row(OP_STORE,   0, 15,  2, 1, 1, EV_MISPRED);
    add_row(OP_ALU,    16,  2,  0, 1, 0, EV_NONE);
    add_row(OP_ALU,    17, 16,  0, 1, 0, EV_NONE);
    add_row(OP_BRANCH,  1,  0,  0, 0, 0, EV_PRED_BTB);
    add_row(OP_ALU,    18,  1,  0, 1, 0, EV_NONE);
    add_row(OP_BRANCH,  0, 18,  0, 1, 0, EV_PRED_NOBTB);
    add_row(OP_ALU,    19,  0,  0, 0, 0, EV_NONE);
    add_row(OP_ALU,    20, 19, 18, 1, 1, EV_NONE);
    add_row(OP_MUL,    21, 20,  0, 1, 0, EV_NONE);
    add_row(OP_ALU,    22, 21,  0, 1, 0, EV_NONE);
  endtask

  // Stores are the only class that never writes rd
  function automatic logic writes(int r);
    return (r >= 0) && (rows[r].op != OP_STORE);
  endfunction

  // Loads (BRAM), CSR reads and M results cannot be bypassed from EX or MEM
  function automatic logic late_result(int r);
    return (r >= 0) && ((rows[r].op == OP_LOAD) || (rows[r].op == OP_CSR) ||
                        (rows[r].op == OP_MUL));
  endfunction

  function automatic logic depends(int prod, reg_idx_t rs, logic used);
    return writes(prod) && (rows[prod].rd != REG_X0) && used && (rows[prod].rd == rs);
  endfunction

  function automatic fwd_sel_e bypass(reg_idx_t rs);
    if (rs == REG_X0) begin
      return FWD_NONE;
    end else if (writes(mem_row) && !late_result(mem_row) && (rows[mem_row].rd == rs)) begin
      return FWD_MEM;
    end else if (writes(wb_row) && (rows[wb_row].rd == rs)) begin
      return FWD_WB;
    end
    return FWD_NONE;
  endfunction

  task automatic drive_inputs();
    if (cur_row >= 0) begin
      in_valid     = 1'b1;
      in_rs1       = rows[cur_row].rs1;
      in_rs2       = rows[cur_row].rs2;
      in_rd        = rows[cur_row].rd;
      in_rs1_used  = rows[cur_row].rs1_used;
      in_rs2_used  = rows[cur_row].rs2_used;
      in_reg_write = rows[cur_row].op != OP_STORE;
      in_op        = rows[cur_row].op;
    end else begin
      in_valid = 1'b0;
    end
    // Redirects and predictions come from the row in EX, mispredictions from MEM
    pc_sel           = PC_SEL_SEQ;
    mispredicted_mem = 1'b0;
    btb_pred_taken   = 1'b0;
    ras_pred_taken   = 1'b0;
    if (ex_row >= 0) begin
      case (rows[ex_row].ev)
        EV_REDIRECT: pc_sel = PC_SEL_REDIRECT;
        EV_PRED_BTB: begin
          pc_sel         = PC_SEL_PREDICTED;
          btb_pred_taken = 1'b1;
        end
        EV_PRED_NOBTB: pc_sel = PC_SEL_PREDICTED;
        default: ;
      endcase
    end
    if ((mem_row >= 0) && (rows[mem_row].ev == EV_MISPRED)) begin
      mispredicted_mem = 1'b1;
    end
  endtask

  task automatic predict();
    logic ex_hit;
    logic mem_hit;
    logic ctrl;
    logic pred;
    ex_hit  = 1'b0;
    mem_hit = 1'b0;
    if (id_row >= 0) begin
      ex_hit  = depends(ex_row, rows[id_row].rs1, rows[id_row].rs1_used) ||
                depends(ex_row, rows[id_row].rs2, rows[id_row].rs2_used);
      mem_hit = depends(mem_row, rows[id_row].rs1, rows[id_row].rs1_used) ||
                depends(mem_row, rows[id_row].rs2, rows[id_row].rs2_used);
    end
    ctrl     = (pc_sel == PC_SEL_REDIRECT) || mispredicted_mem;
    m_hazard = ((ex_hit && late_result(ex_row)) || (mem_hit && late_result(mem_row))) && !ctrl;
    // An M op keeps EX for M_CYCLES cycles, busy on all but the last
    m_busy   = (ex_row >= 0) && (rows[ex_row].op == OP_MUL) && (m_cnt < M_CYCLES - 1);
    pred     = (pc_sel == PC_SEL_PREDICTED) && (!btb_pred_taken || ras_pred_taken) &&
               !m_hazard && !m_busy;
    m_if_id  = ctrl || pred;
    m_id_ex  = ctrl;
    m_ex_mem = mispredicted_mem || m_busy;
    m_issue  = (id_row >= 0) && !m_hazard && !m_busy && !m_if_id;
    m_ready  = (id_row < 0) || m_issue;
  endtask

  task automatic advance(input logic accept);
    logic hold;
    hold    = m_busy && !mispredicted_mem;
    wb_row  = mem_row;
    mem_row = m_ex_mem ? -1 : ex_row;
    if (!hold) begin
      ex_row = m_issue ? id_row : -1;
    end
    m_cnt = hold ? m_cnt + 1 : 0;
    // A flushed cycle also drops whatever was accepted in it
    if (m_if_id) begin
      id_row = -1;
    end else if (accept) begin
      id_row = cur_row;
    end else if (m_issue) begin
      id_row = -1;
    end
  endtask

  // One clock cycle: drive on the falling edge, compare just before the rising edge
  task automatic step();
    logic accept;
    @(negedge clk);
    drive_inputs();
    #1;
    predict();
    check_bit("in_ready", in_ready, m_ready);
    check_bit("data_hazard", data_hazard, m_hazard);
    check_bit("if_id_flush", if_id_flush, m_if_id);
    check_bit("id_ex_flush", id_ex_flush, m_id_ex);
    check_bit("ex_mem_flush", ex_mem_flush, m_ex_mem);
    if (id_row >= 0) begin
      check_fwd("fwd_rs1_sel", fwd_rs1_sel, bypass(rows[id_row].rs1));
      check_fwd("fwd_rs2_sel", fwd_rs2_sel, bypass(rows[id_row].rs2));
    end
    check_bit("ret_valid", ret_valid, wb_row >= 0);
    if (wb_row >= 0) begin
      check_reg("ret_rd", ret_rd, rows[wb_row].rd);
    end
    if (ret_valid === 1'b1) begin
      got_ret++;
    end
    accept = in_valid && m_ready;
    taken  = in_valid && in_ready;
    @(posedge clk);
    advance(accept);
  endtask

  initial begin : watchdog
    wait (cycles >= CYCLE_LIMIT);
    $display("Timeout after %0d cycles with the pipeline still busy", cycles);
    $display("Verification failed");
    $finish;
  end

  initial begin : main
    int gap;
    clk              = 1'b0;
    rst              = 1'b1;
    in_valid         = 1'b0;
    in_rs1           = '0;
    in_rs2           = '0;
    in_rd            = '0;
    in_rs1_used      = 1'b0;
    in_rs2_used      = 1'b0;
    in_reg_write     = 1'b0;
    in_op            = OP_ALU;
    pc_sel           = PC_SEL_SEQ;
    mispredicted_mem = 1'b0;
    btb_pred_taken   = 1'b0;
    ras_pred_taken   = 1'b0;
    id_row  = -1;
    ex_row  = -1;
    mem_row = -1;
    wb_row  = -1;
    m_cnt   = 0;
    cur_row = -1;
    cycles  = 0;
    checks  = 0;
    errors  = 0;
    got_ret = 0;
    num_loaded = 0;
    void'($urandom(32'he492));
    load_table();

    repeat (16) @(posedge clk);
    @(negedge clk);
    // Nothing may leave the pipeline or be flushed straight out of reset
    check_bit("in_ready", in_ready, 1'b0);
    check_bit("ret_valid", ret_valid, 1'b0);
    check_bit("if_id_flush", if_id_flush, 1'b0);
    check_bit("id_ex_flush", id_ex_flush, 1'b0);
    check_bit("ex_mem_flush", ex_mem_flush, 1'b0);
    rst = 1'b0;

    for (int i = 0; i < NUM_ROWS; i++) begin
      gap = $urandom_range(2, 0);
      // Rows behind a control event follow closely so that the flush has victims
      if ((i >= 1 && rows[i - 1].ev != EV_NONE) || (i >= 2 && rows[i - 2].ev != EV_NONE)) begin
        gap = 0;
      end
      cur_row = -1;
      repeat (gap) step();
      cur_row = i;
      taken   = 1'b0;
      while (!taken) begin
        step();
      end
    end
    cur_row = -1;
    while (id_row >= 0 || ex_row >= 0 || mem_row >= 0 || wb_row >= 0) begin
      step();
    end
    repeat (2) step();

    $display("Summary: %0d checks, %0d errors, %0d retired", checks, errors, got_ret);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* rv_pipe_ctrl.f */
src/rv_isa_pkg.sv
src/rv_pipe_pkg.sv
src/rv_dest_if.sv
src/rv_id_stage.sv
src/rv_stage_track.sv
src/rv_hazard.sv
src/rv_fwd_id.sv
src/rv_pipe_ctrl.sv
sim/tb_rv_pipe_ctrl.sv
